/* Bender.yml */
package:
  name: conv_pad

sources:
  - files:
      - design/conv_pad_pkg.sv
      - design/col_sequencer.sv
      - design/pad_filter.sv
      - design/partial_sum_pipe.sv
      - design/pad_mask_gate.sv
      - design/conv_pad_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/conv_pad_tb.sv

/* conv_pad_top.f */
+incdir+verif
design/conv_pad_pkg.sv
design/col_sequencer.sv
design/pad_filter.sv
design/partial_sum_pipe.sv
design/pad_mask_gate.sv
design/conv_pad_top.sv
verif/conv_pad_tb.sv

/* design/col_sequencer.sv */
/*
 * Frame sequencer. Walks the channel beats of each column of one frame.
 * A start is taken only while idle and with aclken high.
 * A beat counts only with beat_valid and aclken high while a frame runs.
 * The tag and tvalid are combinational from the counters of the current beat.
 */
module col_sequencer
    import conv_pad_pkg::*;
#(
    parameter int MEMBERS = 8,
    parameter int DATA_W  = 16
) (
    input  logic                            aclk,
    input  logic                            arst_n,
    input  logic                            aclken,
    input  logic                            start,
    input  frame_cfg_t                      cfg,
    input  logic                            beat_valid,
    input  logic [MEMBERS-1:0][DATA_W-1:0]  prod,
    output logic                            tvalid,
    output pad_tuser_t                      tuser,
    output logic [MEMBERS-1:0][DATA_W-1:0]  prod_out
);

    seq_state_e          state;     // idle or inside a frame
    frame_cfg_t          cfg_q;     // setup of the running frame
    logic [CIN_BITS-1:0] cin_cnt;   // channel beat within the column
    logic [COL_BITS-1:0] col_cnt;   // column within the frame
    logic                cin_last;  // current beat closes its column
    logic                col_last;  // current column is the last one
    logic                beat_en;   // beat that advances the counters
    logic [COL_BITS-1:0] col_1_k2;  // column index cols-1-kw/2

    assign cin_last = cin_cnt == CIN_BITS'(cfg_q.cin_count - 1'b1);
    assign col_last = col_cnt == COL_BITS'(cfg_q.cols - 1'b1);
    assign col_1_k2 = COL_BITS'(cfg_q.cols - 1'b1 - (cfg_q.kernel_w >> 1));

    assign tvalid  = beat_valid && (state == SEQ_RUN); // enable is applied by each consumer
    assign beat_en = tvalid && aclken;

    assign tuser = '{
        kernel_w:     cfg_q.kernel_w,
        is_cols_1_k2: col_cnt == col_1_k2,
        is_cin_last:  cin_last,
        col:          col_cnt
    };

    assign prod_out = prod; // products ride on the same beat as their tag

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= SEQ_IDLE;
            cfg_q   <= '0;
            cin_cnt <= '0;
            col_cnt <= '0;
        end else if (aclken) begin
            if (state == SEQ_IDLE) begin
                if (start) begin
                    state   <= SEQ_RUN; // counters were left at zero by the last frame
                    cfg_q   <= cfg;
                    cin_cnt <= '0;
                    col_cnt <= '0;
                end
            end else if (beat_en) begin
                if (!cin_last) begin
                    cin_cnt <= cin_cnt + 1'b1;
                end else begin
                    cin_cnt <= '0;
                    if (col_last) begin
                        col_cnt <= '0;
                        state   <= SEQ_IDLE; // idle in the cycle after the last beat
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // an accepted start must bring an odd width, a nonempty column and cols >= width
    assert property (@(posedge aclk) disable iff (!arst_n)
        (aclken && start && state == SEQ_IDLE) |->
            (cfg.kernel_w[0] && cfg.cin_count != '0 && cfg.cols >= COL_BITS'(cfg.kernel_w)));

endmodule

/* design/conv_pad_pkg.sv */
/*
 * Shared widths and types of the horizontal padding output stage.
 * KW_BITS = 3 covers odd kernel widths up to 7. Widen it for larger kernels.
 * Frames hold at most 2**COL_BITS - 1 columns and 2**CIN_BITS - 1 channel beats.
 */
package conv_pad_pkg;

    localparam int KW_BITS  = 3;           // odd kernel width, 1..7
    localparam int COL_BITS = 7;           // column count and column index
    localparam int CIN_BITS = 6;           // input channel beats per column
    localparam int CLR_BITS = KW_BITS + 1; // center/left/right code

    typedef logic [CLR_BITS-1:0] clr_t; // 0 center, odd left, even nonzero right

    // tag that travels with every beat of the frame
    typedef struct packed {
        logic [KW_BITS-1:0]  kernel_w;     // kernel width of the running frame
        logic                is_cols_1_k2; // beat belongs to column cols-1-kw/2
        logic                is_cin_last;  // last channel beat of the column
        logic [COL_BITS-1:0] col;          // column index
    } pad_tuser_t;

    // frame setup, sampled on an accepted start
    typedef struct packed {
        logic [KW_BITS-1:0]  kernel_w;  // must be odd
        logic [COL_BITS-1:0] cols;      // at least kernel_w
        logic [CIN_BITS-1:0] cin_count; // at least 1
    } frame_cfg_t;

    // per column side data of the pad filter result
    typedef struct packed {
        logic                valid; // one cycle strobe per finished column
        clr_t                clr;   // padding position of the column
        logic [COL_BITS-1:0] col;   // column the masks belong to
    } pf_meta_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

    // width of the pad filter bundle {mask_full, mask_partial[MEMBERS-1:1], meta}
    function automatic int pf_bits(input int members);
        return 2 * members - 1 + $bits(pf_meta_t);
    endfunction

endpackage

/* design/conv_pad_top.sv */
/*
 * Output stage with horizontal zero padding for same-size convolution.
 * No back-pressure, beat_valid is a plain strobe qualified by aclken.
 * out_valid for a column rises two cycles after its last enabled channel beat.
 */
module conv_pad_top
    import conv_pad_pkg::*;
#(
    parameter int KERNEL_W_MAX = 7,
    parameter int MEMBERS      = 8,
    parameter int DATA_W       = 16,
    parameter int SUM_W        = 24
) (
    input  logic                           aclk,
    input  logic                           arst_n,
    input  logic                           aclken,
    input  logic                           start,
    input  frame_cfg_t                     cfg,
    input  logic                           beat_valid,
    input  logic [MEMBERS-1:0][DATA_W-1:0] prod,
    output logic                           out_valid,
    output logic [MEMBERS-1:0]             out_full,
    output logic [MEMBERS-1:0]             out_partial,
    output logic [MEMBERS-1:0][SUM_W-1:0]  out_sum,
    output clr_t                           out_clr,
    output logic [COL_BITS-1:0]            out_col
);

    logic                           seq_tvalid; // tagged beat inside a frame
    pad_tuser_t                     seq_tuser;
    logic [MEMBERS-1:0][DATA_W-1:0] seq_prod;
    logic [pf_bits(MEMBERS)-1:0]    pf_out;     // masks, clr and column of a column
    logic [MEMBERS-1:0][SUM_W-1:0]  sums;
    logic                           sum_valid;

    col_sequencer #(.MEMBERS(MEMBERS), .DATA_W(DATA_W)) u_seq (
        .aclk, .arst_n, .aclken, .start, .cfg, .beat_valid, .prod,
        .tvalid(seq_tvalid), .tuser(seq_tuser), .prod_out(seq_prod)
    );

    pad_filter #(.KERNEL_W_MAX(KERNEL_W_MAX), .MEMBERS(MEMBERS)) u_pad (
        .aclk, .arst_n, .aclken,
        .tvalid(seq_tvalid), .tuser(seq_tuser), .pf_out
    );

    partial_sum_pipe #(.MEMBERS(MEMBERS), .DATA_W(DATA_W), .SUM_W(SUM_W)) u_psum (
        .aclk, .arst_n, .aclken,
        .tvalid(seq_tvalid), .tuser(seq_tuser), .prod(seq_prod), .sums, .sum_valid
    );

    pad_mask_gate #(.MEMBERS(MEMBERS), .SUM_W(SUM_W)) u_gate (
        .aclk, .arst_n, .aclken, .pf_out, .sums, .sum_valid,
        .out_valid, .out_full, .out_partial, .out_sum, .out_clr, .out_col
    );

endmodule

/* design/pad_filter.sv */
/*
 * Horizontal padding masks for same-size convolution.
 * Any odd kernel width up to KERNEL_W_MAX, selectable per frame.
 * Mask tables exist for every odd width, the frame width picks one.
 * All members share one tag, so one pair of column chains serves them all.
 * Results appear on pf_out one cycle after the last channel beat of a column.
 */
module pad_filter
    import conv_pad_pkg::*;
#(
    parameter int KERNEL_W_MAX = 7,
    parameter int MEMBERS      = 8
) (
    input  logic                        aclk,
    input  logic                        arst_n,
    input  logic                        aclken,
    input  logic                        tvalid,
    input  pad_tuser_t                  tuser,
    output logic [pf_bits(MEMBERS)-1:0] pf_out
);

    localparam int KW2_MAX = KERNEL_W_MAX / 2; // 7 gives 3

    logic [KW_BITS-2:0]  kw2;         // kw/2 of the frame
    logic                col_en;      // last channel beat, enabled
    logic                last_col;    // current column is cols-1
    logic [KW2_MAX:0]    end_cur;     // bit k high on column cols-1-kw2+k
    logic [KW2_MAX:1]    col_end_q;   // earlier is_cols_1_k2 flags, shifted
    logic [KW2_MAX:1]    col_start_q; // bit k high on column k-1
    logic [KW2_MAX:1]    start_zone;  // bit k high on the first k columns
    logic [KW2_MAX:0]    full_lut [MEMBERS];
    logic [KW2_MAX:0]    part_lut [MEMBERS-1:1];
    logic [MEMBERS-1:0]  full_d;
    logic [MEMBERS-1:1]  part_d;
    clr_t                clr_d;

    logic [MEMBERS-1:0]  full_q;
    logic [MEMBERS-1:1]  part_q;
    logic                pf_valid_q;
    clr_t                clr_q;
    logic [COL_BITS-1:0] col_q;

    assign kw2      = tuser.kernel_w[KW_BITS-1:1];
    assign col_en   = aclken && tvalid && tuser.is_cin_last;
    assign end_cur  = {col_end_q, tuser.is_cols_1_k2};
    assign last_col = end_cur[kw2]; // kw = 1 flags cols-1 directly

    // chains step once per column and restart at the last column of a frame
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            col_end_q   <= '0;
            col_start_q <= KW2_MAX'(1); // first column of the first frame
        end else if (col_en) begin
            if (last_col) begin
                col_end_q   <= '0;
                col_start_q <= KW2_MAX'(1);
            end else begin
                col_end_q   <= end_cur[KW2_MAX-1:0];
                col_start_q <= col_start_q << 1;
            end
        end
    end

    for (genvar k = 1; k <= KW2_MAX; k++) begin : g_zone
        assign start_zone[k] = |col_start_q[k:1]; // column below k
    end

    for (genvar m = 0; m < MEMBERS; m++) begin : g_member
        assign full_lut[m][0] = 1'b1; // kw = 1 passes every member
        for (genvar k = 1; k <= KW2_MAX; k++) begin : g_full
            localparam int KW = 2 * k + 1;
            localparam int J  = m % KW;            // tap of this member
            localparam int U  = (MEMBERS / KW) * KW; // members of whole windows
            // full sums from the center, plus formed sums at the last column
            assign full_lut[m][k] = ((J == KW - 1) && !start_zone[k]) ||
                                    (last_col && (J >= k) && (m < U));
        end
        assign full_d[m] = full_lut[m][kw2];
    end

    for (genvar m = 1; m < MEMBERS; m++) begin : g_part_member
        assign part_lut[m][0] = 1'b0; // kw = 1 has no partial sums
        for (genvar k = 1; k <= KW2_MAX; k++) begin : g_part
            localparam int KW = 2 * k + 1;
            localparam int J  = m % KW;
            localparam int U  = (MEMBERS / KW) * KW;
            localparam int LO = (J > 1) ? J : 1;
            if (LO <= k) begin : g_tri
                // blocked from column cols-1-kw2+max(j,1) on
                assign part_lut[m][k] = (m < U) && !(|end_cur[k:LO]);
            end else begin : g_open
                assign part_lut[m][k] = (m < U);
            end
        end
        assign part_d[m] = part_lut[m][kw2];
    end

    always_comb begin
        clr_d = '0; // center unless a chain bit says otherwise
        for (int k = 1; k <= KW2_MAX; k++) begin
            if (k <= kw2 && col_start_q[k]) begin
                clr_d = CLR_BITS'(2 * k - 1);         // left column k-1
            end
            if (k <= kw2 && end_cur[k]) begin
                clr_d = CLR_BITS'(2 * (kw2 - k) + 2); // right, kw2-k from the edge
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pf_valid_q <= 1'b0;
        end else if (aclken) begin
            pf_valid_q <= tvalid && tuser.is_cin_last;
        end
    end

    always_ff @(posedge aclk) begin
        if (col_en) begin
            full_q <= full_d;
            part_q <= part_d;
            clr_q  <= clr_d;
            col_q  <= tuser.col;
        end
    end

    assign pf_out = {full_q, part_q, pf_meta_t'{valid: pf_valid_q, clr: clr_q, col: col_q}};

    // the lookup only knows odd widths up to the synthesized maximum
    assert property (@(posedge aclk) disable iff (!arst_n)
        tvalid |-> (tuser.kernel_w[0] && tuser.kernel_w <= KERNEL_W_MAX));

endmodule

/* design/pad_mask_gate.sv */
/*
 * Joins pad filter masks with the column sums of the same column.
 * A member passes its sum when its full or partial mask is set, else it reads zero.
 * Both inputs must arrive on the same cycle, there is no alignment buffer.
 */
module pad_mask_gate
    import conv_pad_pkg::*;
#(
    parameter int MEMBERS = 8,
    parameter int SUM_W   = 24
) (
    input  logic                          aclk,
    input  logic                          arst_n,
    input  logic                          aclken,
    input  logic [pf_bits(MEMBERS)-1:0]   pf_out,
    input  logic [MEMBERS-1:0][SUM_W-1:0] sums,
    input  logic                          sum_valid,
    output logic                          out_valid,
    output logic [MEMBERS-1:0]            out_full,
    output logic [MEMBERS-1:0]            out_partial,
    output logic [MEMBERS-1:0][SUM_W-1:0] out_sum,
    output clr_t                          out_clr,
    output logic [COL_BITS-1:0]           out_col
);

    logic [MEMBERS-1:0] pf_full;
    logic [MEMBERS-1:1] pf_partial;
    pf_meta_t           pf_meta;
    logic [MEMBERS-1:0] keep;   // member contributes to the output column
    logic               col_en; // both halves of a column present, enabled

    assign {pf_full, pf_partial, pf_meta} = pf_out;
    assign keep   = pf_full | {pf_partial, 1'b0}; // member 0 has no partial mask
    assign col_en = aclken && pf_meta.valid && sum_valid;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (aclken) begin
            out_valid <= pf_meta.valid && sum_valid; // holds with the enable low
        end
    end

    always_ff @(posedge aclk) begin
        if (col_en) begin
            out_full    <= pf_full;
            out_partial <= {pf_partial, 1'b0};
            out_clr     <= pf_meta.clr;
            out_col     <= pf_meta.col;
            for (int m = 0; m < MEMBERS; m++) begin
                out_sum[m] <= keep[m] ? sums[m] : '0;
            end
        end
    end

    // both paths have one register stage after the last channel beat
    assert property (@(posedge aclk) disable iff (!arst_n)
        pf_meta.valid == sum_valid);

endmodule

/* design/partial_sum_pipe.sv */
/*
 * Per-member channel accumulators.
 * Products are signed, sums are sign extended to SUM_W without saturation.
 * A column sum leaves one cycle after the last channel beat of its column.
 */
module partial_sum_pipe
    import conv_pad_pkg::*;
#(
    parameter int MEMBERS = 8,
    parameter int DATA_W  = 16,
    parameter int SUM_W   = 24
) (
    input  logic                           aclk,
    input  logic                           arst_n,
    input  logic                           aclken,
    input  logic                           tvalid,
    input  pad_tuser_t                     tuser,
    input  logic [MEMBERS-1:0][DATA_W-1:0] prod,
    output logic [MEMBERS-1:0][SUM_W-1:0]  sums,
    output logic                           sum_valid
);

    logic signed [SUM_W-1:0] acc      [MEMBERS]; // running sum of the open column
    logic signed [SUM_W-1:0] acc_next [MEMBERS]; // sum including this beat
    logic                    beat_en;

    assign beat_en = aclken && tvalid;

    for (genvar m = 0; m < MEMBERS; m++) begin : g_add
        assign acc_next[m] = acc[m] + SUM_W'($signed(prod[m])); // sign extend first
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            sum_valid <= 1'b0;
            for (int m = 0; m < MEMBERS; m++) begin
                acc[m] <= '0;
            end
        end else if (aclken) begin
            sum_valid <= tvalid && tuser.is_cin_last;
            for (int m = 0; m < MEMBERS; m++) begin
                if (beat_en) begin
                    acc[m] <= tuser.is_cin_last ? '0 : acc_next[m]; // next column starts clean
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (beat_en && tuser.is_cin_last) begin
            for (int m = 0; m < MEMBERS; m++) begin
                sums[m] <= acc_next[m];
            end
        end
    end

endmodule

/* verif/pad_ref_model.svh */
/*
 * Reference model of the padding output stage, included inside the testbench module.
 * Needs MEMBERS, DATA_W and SUM_W in scope and assumes cols >= kernel width.
 * Sums wrap at SUM_W bits, as the accumulators do.
 */
`ifndef PAD_REF_MODEL_SVH
`define PAD_REF_MODEL_SVH

typedef logic [MEMBERS-1:0][DATA_W-1:0] prod_vec_t;
typedef logic [MEMBERS-1:0][SUM_W-1:0]  sum_vec_t;

// member m closes a whole window, or a window ends at the right edge
function automatic logic [MEMBERS-1:0] ref_full(input int kw, input int cols, input int c);
    logic [MEMBERS-1:0] mask;
    int u;
    u = (MEMBERS / kw) * kw; // members from u on hold no complete window
    for (int m = 0; m < MEMBERS; m++) begin
        mask[m] = ((m % kw == kw - 1) && c >= kw / 2) ||
                  (c == cols - 1 && m % kw >= kw / 2 && m < u);
    end
    return mask;
endfunction

// a partial sum is needed until the right padding reaches tap max(j,1)
function automatic logic [MEMBERS-1:0] ref_partial(input int kw, input int cols, input int c);
    logic [MEMBERS-1:0] mask;
    int lo;
    mask = '0; // member 0 never carries a partial sum
    for (int m = 1; m < MEMBERS; m++) begin
        lo = (m % kw > 1) ? m % kw : 1;
        mask[m] = kw > 1 && m < (MEMBERS / kw) * kw && c < cols - 1 - kw / 2 + lo;
    end
    return mask;
endfunction

function automatic clr_t ref_clr(input int kw, input int cols, input int c);
    if (c < kw / 2)
        return clr_t'(2 * c + 1); // left padded column c
    if (c > cols - 1 - kw / 2)
        return clr_t'(2 * (cols - 1 - c) + 2); // right padded, counted from the edge
    return '0;
endfunction

function automatic sum_vec_t ref_accumulate(input sum_vec_t acc, input prod_vec_t p);
    for (int m = 0; m < MEMBERS; m++) begin
        acc[m] = acc[m] + {{(SUM_W - DATA_W){p[m][DATA_W-1]}}, p[m]}; // products are signed
    end
    return acc;
endfunction

function automatic sum_vec_t ref_gate(input sum_vec_t acc, input logic [MEMBERS-1:0] keep);
    for (int m = 0; m < MEMBERS; m++) begin
        acc[m] = keep[m] ? acc[m] : '0; // blocked members read zero
    end
    return acc;
endfunction

`endif

/* verif/conv_pad_tb.sv */
/*
 * Testbench of the padding output stage. Columns are checked in order on out_valid.
 * Output timing is counted in enabled cycles and must be two after each last channel beat.
 * Frames keep cols >= kernel width and widths within KERNEL_W_MAX.
 */
module conv_pad_tb
    import conv_pad_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          KERNEL_W_MAX = 7;
    localparam int          MEMBERS      = 8;
    localparam int          DATA_W       = 16;
    localparam int          SUM_W        = 24;
    localparam logic [31:0] SEED         = 32'h8533_0baf;
    localparam int          TOTAL_BEATS  = 20 + 27 + 24 + 12 + 8 + 7 + 7 + 33 + 5; // frames and idle
    localparam int          TIMEOUT      = 2 * TOTAL_BEATS + 200;

    `include "pad_ref_model.svh"

    typedef struct packed {
        logic [MEMBERS-1:0]  full;
        logic [MEMBERS-1:0]  partial;
        sum_vec_t            sum;
        clr_t                clr;
        logic [COL_BITS-1:0] col;
    } exp_col_t;

    logic aclk, arst_n, aclken, start, beat_valid, out_valid;
    logic exp_last; // marks the last channel beat of a column
    frame_cfg_t cfg;
    prod_vec_t prod;
    logic [MEMBERS-1:0] out_full, out_partial;
    sum_vec_t out_sum;
    clr_t out_clr;
    logic [COL_BITS-1:0] out_col;
    exp_col_t exp_q[$]; // expected columns in output order
    int due_q[$];       // enabled cycle at which each column must be taken
    int en_cycles = 0;
    logic en_prev = 1'b1;
    logic rst_seen = 1'b0; // reset has reached the DUT at an earlier edge
    logic [$bits(exp_col_t):0] snap_prev = '0;

    conv_pad_top #(.KERNEL_W_MAX(KERNEL_W_MAX), .MEMBERS(MEMBERS), .DATA_W(DATA_W),
                   .SUM_W(SUM_W)) UUT (
        .aclk, .arst_n, .aclken, .start, .cfg, .beat_valid, .prod,
        .out_valid, .out_full, .out_partial, .out_sum, .out_clr, .out_col
    );

    always #20 aclk = ~aclk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_masks(input logic [MEMBERS-1:0] got, input logic [MEMBERS-1:0] want,
                               input string kind, input int col);
        if (got !== want)
            abort_run($sformatf(
                "Mismatch at time %0t: %s mask of column %0d is %b, expected %b",
                $time, kind, col, got, want));
    endtask

    task automatic check_sums(input sum_vec_t got, input sum_vec_t want, input int col);
        for (int m = 0; m < MEMBERS; m++) begin
            if (got[m] !== want[m])
                abort_run($sformatf(
                    "Mismatch at time %0t: sum %0d of column %0d is %h, expected %h",
                    $time, m, col, got[m], want[m]));
        end
    endtask

    task automatic check_clr(input clr_t got_clr, input clr_t want_clr,
                             input logic [COL_BITS-1:0] got_col,
                             input logic [COL_BITS-1:0] want_col);
        if (got_clr !== want_clr || got_col !== want_col)
            abort_run($sformatf(
                "Mismatch at time %0t: column %0d clr %0d, expected column %0d clr %0d",
                $time, got_col, got_clr, want_col, want_clr));
    endtask

    task automatic idle_beats(input int n, input bit valid);
        repeat (n) begin
            @(posedge aclk);
            aclken     <= 1'b1;
            start      <= 1'b0;
            beat_valid <= valid; // beats outside a frame must be ignored
            exp_last   <= 1'b0;
            prod       <= {MEMBERS{DATA_W'($urandom)}};
        end
    endtask

    // drop turns on random aclken gaps and stray_start is a beat index or -1
    task automatic run_frame(input int kw, input int cols, input int cin, input bit drop,
                             input int stray_start);
        sum_vec_t acc;
        prod_vec_t p;
        exp_col_t e;
        bit en;
        int beat;
        beat = 0;
        @(posedge aclk);
        aclken     <= 1'b1;
        start      <= 1'b1;
        cfg        <= '{kernel_w: KW_BITS'(kw), cols: COL_BITS'(cols), cin_count: CIN_BITS'(cin)};
        beat_valid <= 1'b0;
        exp_last   <= 1'b0;
        for (int c = 0; c < cols; c++) begin
            acc = '0;
            for (int i = 0; i < cin; i++) begin
                for (int m = 0; m < MEMBERS; m++)
                    p[m] = DATA_W'($urandom);
                acc = ref_accumulate(acc, p);
                do begin
                    @(posedge aclk);
                    en = drop ? ($urandom_range(3) != 0) : 1'b1;
                    aclken     <= en; // beat is repeated until an enabled edge takes it
                    start      <= (beat == stray_start);
                    beat_valid <= 1'b1;
                    prod       <= p;
                    exp_last   <= (i == cin - 1);
                    if (beat == stray_start)
                        cfg <= '{kernel_w: KW_BITS'(1), cols: COL_BITS'(3), cin_count: CIN_BITS'(1)};
                end while (!en);
                beat++;
            end
            e.full    = ref_full(kw, cols, c);
            e.partial = ref_partial(kw, cols, c);
            e.sum     = ref_gate(acc, e.full | e.partial);
            e.clr     = ref_clr(kw, cols, c);
            e.col     = COL_BITS'(c);
            exp_q.push_back(e);
        end
    endtask

    // takes a column on every enabled edge with out_valid and checks holds with aclken low
    always @(posedge aclk) begin : compare
        exp_col_t want;
        int due;
        logic [$bits(exp_col_t):0] snap;
        snap = {out_valid, out_full, out_partial, out_sum, out_clr, out_col};
        if (!arst_n) begin
            if (rst_seen && out_valid !== 1'b0)
                abort_run("out_valid was not low during reset");
            rst_seen = 1'b1;
        end else begin
            if (!en_prev && snap !== snap_prev)
                abort_run("outputs changed while aclken was low");
            if (aclken) begin
                en_cycles++;
                if (exp_last)
                    due_q.push_back(en_cycles + 2);
                if (out_valid) begin
                    if (exp_q.size() == 0)
                        abort_run("out_valid was raised with no column expected");
                    want = exp_q.pop_front();
                    due  = due_q.pop_front();
                    if (en_cycles != due)
                        abort_run($sformatf(
                            "Mismatch at time %0t: column %0d came at cycle %0d, not %0d",
                            $time, want.col, en_cycles, due));
                    check_clr(out_clr, want.clr, out_col, want.col);
                    check_masks(out_full, want.full, "full", want.col);
                    check_masks(out_partial, want.partial, "partial", want.col);
                    check_sums(out_sum, want.sum, want.col);
                end
            end
        end
        en_prev   = aclken;
        snap_prev = snap;
    end

    initial begin : watchdog
        int cycle_cnt;
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        abort_run("timeout, no output arrived in time");
    end

    initial begin : stimulus
        int drain;
        aclk       = 1'b0;
        arst_n     = 1'b0;
        aclken     = 1'b0;
        start      = 1'b0;
        cfg        = '0;
        beat_valid = 1'b0;
        exp_last   = 1'b0;
        prod       = '0;
        void'($urandom(SEED));
        repeat (2) @(posedge aclk);
        arst_n <= 1'b1;
        idle_beats(5, 1'b1);         // beats while idle
        run_frame(3, 10, 2, 0, 7);   // stray start in the middle of the frame
        idle_beats(2, 1'b0);
        run_frame(5, 9, 3, 0, -1);
        run_frame(7, 12, 2, 0, -1);  // widest kernel leaves member 7 unused
        run_frame(1, 6, 2, 0, -1);
        idle_beats(2, 1'b0);
        run_frame(3, 8, 1, 0, -1);   // back to back frames with one beat per column
        run_frame(5, 7, 1, 0, -1);
        run_frame(7, 7, 1, 0, -1);
        run_frame(5, 11, 3, 1, -1);  // random aclken gaps
        idle_beats(1, 1'b0);
        drain = 0;
        while (exp_q.size() != 0 && drain < 20) begin
            @(posedge aclk);
            drain++;
        end
        repeat (5) @(posedge aclk);  // any extra column would show here
        if (exp_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("%0d expected columns never came out", exp_q.size());
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule
